/* Bender.yml */
package:
  name: rvcore

sources:
  - verilog/rvPkg.sv
  - verilog/rvDecoder.sv
  - verilog/rvImmGen.sv
  - verilog/rvRegFile.sv
  - verilog/rvAlu.sv
  - verilog/rvCore.sv
  - target: test
    files:
      - tests/rvClockGen.sv
      - tests/rvCoreTb.sv

/* sim.f */
verilog/rvPkg.sv
verilog/rvDecoder.sv
verilog/rvImmGen.sv
verilog/rvRegFile.sv
verilog/rvAlu.sv
verilog/rvCore.sv
tests/rvClockGen.sv
tests/rvCoreTb.sv

/* tests/rvClockGen.sv */
module rvClockGen (
  output logic clk,
  output logic rstN
);

  localparam int halfPeriod = 2;
  localparam int resetCycles = 3;

  initial begin
    clk = 1'b0;
    forever begin
      #halfPeriod clk = ~clk;
    end
  end

  // Reset drops on a falling edge like the other DUT inputs
  initial begin
    // Real falling edge ahead of the first clock so the asynchronous reset acts
    rstN = 1'b1;
    #1;
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rstN <= 1'b1;
  end

endmodule

/* tests/rvCoreTb.sv */
module rvCoreTb;

  localparam int imemWords = 128;
  localparam int dmemWords = 64;
  localparam int haltTail = 6;
  localparam rvPkg::xlenT dataBase = 32'h0000_0100;
  localparam rvPkg::xlenT ebreakWord = 32'h0010_0073;
  localparam rvPkg::xlenT nopWord = 32'h0000_0013;

  logic clk;
  logic rstN;
  rvPkg::xlenT inst;
  rvPkg::xlenT pc;
  rvPkg::xlenT dataRData;
  rvPkg::xlenT dataAddr;
  rvPkg::xlenT dataWData;
  logic dataWe;
  logic halt;

  rvPkg::xlenT imem [0:imemWords-1];
  rvPkg::xlenT dmem [0:dmemWords-1];
  int progLen;
  int cycleLimit;
  int cycleCount;
  int storeCount;
  logic [31:0] lcgState;

  // Reference model state and its predictions for the current cycle
  rvPkg::xlenT mPc;
  rvPkg::xlenT mRegs [0:31];
  rvPkg::xlenT mMem [0:dmemWords-1];
  logic mHalt;
  rvPkg::xlenT expPc;
  logic expHalt;
  logic expWe;
  rvPkg::xlenT expAddr;
  rvPkg::xlenT expWData;

  int resetErrors;
  int pcErrors;
  int storeErrors;
  int haltErrors;

  rvClockGen clockGen (
    .clk(clk),
    .rstN(rstN)
  );

  rvCore rvCore_inst (
    .clk(clk),
    .rstN(rstN),
    .inst(inst),
    .pc(pc),
    .dataRData(dataRData),
    .dataAddr(dataAddr),
    .dataWData(dataWData),
    .dataWe(dataWe),
    .halt(halt)
  );

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Untouched data words differ in every address bit
  function automatic rvPkg::xlenT fillWord(rvPkg::xlenT addr);
    return ~addr ^ {addr[15:0], addr[31:16]};
  endfunction

  function automatic logic inDataRange(rvPkg::xlenT addr);
    return addr >= dataBase && addr < dataBase + 32'(4 * dmemWords);
  endfunction

  function automatic int dataIndex(rvPkg::xlenT addr);
    return (addr - dataBase) >> 2;
  endfunction

  function automatic rvPkg::xlenT fetchWord(rvPkg::xlenT addr);
    int idx;
    idx = (addr - rvPkg::resetPc) >> 2;
    if (idx < progLen) begin
      return imem[idx];
    end
    return nopWord;
  endfunction

  function automatic rvPkg::xlenT encodeR(logic [6:0] funct7, rvPkg::regAddrT rs2,
                                          rvPkg::regAddrT rs1, rvPkg::regAddrT rd);
    return {funct7, rs2, rs1, 3'b000, rd, rvPkg::opOp};
  endfunction

  function automatic rvPkg::xlenT encodeI(logic [11:0] imm, rvPkg::regAddrT rs1,
                                          logic [2:0] funct3, rvPkg::regAddrT rd,
                                          logic [6:0] op);
    return {imm, rs1, funct3, rd, op};
  endfunction

  function automatic rvPkg::xlenT encodeS(logic [11:0] imm, rvPkg::regAddrT rs2,
                                          rvPkg::regAddrT rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvPkg::opStore};
  endfunction

  function automatic rvPkg::xlenT encodeU(logic [19:0] imm, rvPkg::regAddrT rd,
                                          logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic rvPkg::xlenT encodeJ(logic [20:0] off, rvPkg::regAddrT rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rvPkg::opJal};
  endfunction

  task automatic emit(rvPkg::xlenT word);
    imem[progLen] = word;
    progLen++;
  endtask

  task automatic buildProgram();
    logic [31:0] r;
    rvPkg::regAddrT rd;
    rvPkg::regAddrT rs1;
    rvPkg::regAddrT rs2;
    int kind;
    progLen = 0;
    // Random arithmetic on x0..x23 that opens with addi to seed values
    for (int i = 0; i < 24; i++) begin
      r = nextRandom();
      rd = rvPkg::regAddrT'(r[15:4] % 24);
      rs1 = rvPkg::regAddrT'(r[21:16] % 24);
      rs2 = rvPkg::regAddrT'(r[27:22] % 24);
      kind = (i < 6) ? 0 : int'(r[31:28] % 3);
      case (kind)
        0: emit(encodeI(r[31:20], rs1, 3'b000, rd, rvPkg::opOpImm));
        1: emit(encodeR(7'b0000000, rs2, rs1, rd));
        default: emit(encodeR(7'b0100000, rs2, rs1, rd));
      endcase
    end
    // x31 points at the data region where x0..x23 are dumped
    emit(encodeI(12'h100, 5'd0, 3'b000, 5'd31, rvPkg::opOpImm));
    for (int i = 0; i < 24; i++) begin
      emit(encodeS(12'(4 * i), rvPkg::regAddrT'(i), 5'd31));
    end
    r = nextRandom();
    emit(encodeU(r[31:12], 5'd24, rvPkg::opLui));
    emit(encodeS(12'h060, 5'd24, 5'd31));
    r = nextRandom();
    emit(encodeU(r[31:12], 5'd25, rvPkg::opAuipc));
    emit(encodeS(12'h064, 5'd25, 5'd31));
    // Reload the word stored from x5 and then a never written word
    emit(encodeI(12'h014, 5'd31, 3'b010, 5'd26, rvPkg::opLoad));
    emit(encodeS(12'h068, 5'd26, 5'd31));
    emit(encodeI(12'h0f0, 5'd31, 3'b010, 5'd26, rvPkg::opLoad));
    emit(encodeS(12'h06c, 5'd26, 5'd31));
    // jal skips two increments
    emit(encodeJ(21'd12, 5'd27));
    emit(encodeI(12'd1, 5'd1, 3'b000, 5'd1, rvPkg::opOpImm));
    emit(encodeI(12'd1, 5'd2, 3'b000, 5'd2, rvPkg::opOpImm));
    // Odd jalr offset that lands 16 bytes past the auipc
    emit(encodeU(20'd0, 5'd28, rvPkg::opAuipc));
    emit(encodeI(12'd17, 5'd28, 3'b000, 5'd29, rvPkg::opJalr));
    emit(encodeI(12'd1, 5'd3, 3'b000, 5'd3, rvPkg::opOpImm));
    emit(encodeI(12'd1, 5'd4, 3'b000, 5'd4, rvPkg::opOpImm));
    emit(encodeS(12'h070, 5'd27, 5'd31));
    emit(encodeS(12'h074, 5'd28, 5'd31));
    emit(encodeS(12'h078, 5'd29, 5'd31));
    // Skipped increments must not show
    for (int i = 1; i < 5; i++) begin
      emit(encodeS(12'(120 + 4 * i), rvPkg::regAddrT'(i), 5'd31));
    end
    emit(ebreakWord);
    cycleLimit = 2 * progLen + 20;
  endtask

  task automatic resetModel();
    mPc = rvPkg::resetPc;
    mHalt = 1'b0;
    for (int i = 0; i < 32; i++) begin
      mRegs[i] = '0;
    end
  endtask

  // One instruction of the ISA straight from the encoding
  task automatic stepModel();
    rvPkg::xlenT ins;
    rvPkg::xlenT immI;
    rvPkg::xlenT immS;
    rvPkg::xlenT immU;
    rvPkg::xlenT immJ;
    rvPkg::xlenT src1;
    rvPkg::xlenT src2;
    rvPkg::xlenT result;
    rvPkg::xlenT target;
    rvPkg::xlenT addr;
    logic writes;
    ins = fetchWord(mPc);
    immI = {{20{ins[31]}}, ins[31:20]};
    immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    immU = {ins[31:12], 12'h000};
    immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    src1 = mRegs[ins[19:15]];
    src2 = mRegs[ins[24:20]];
    result = mPc + 32'd4;
    target = mPc + 32'd4;
    writes = 1'b1;
    case (ins[6:0])
      rvPkg::opLui: result = immU;
      rvPkg::opAuipc: result = mPc + immU;
      rvPkg::opJal: target = mPc + immJ;
      rvPkg::opJalr: target = (src1 + immI) & ~32'd1;
      rvPkg::opOpImm: result = src1 + immI;
      rvPkg::opOp: result = ins[30] ? src1 - src2 : src1 + src2;
      rvPkg::opLoad: begin
        addr = src1 + immI;
        result = inDataRange(addr) ? mMem[dataIndex(addr)] : fillWord(addr);
      end
      rvPkg::opStore: begin
        writes = 1'b0;
        addr = src1 + immS;
        if (inDataRange(addr)) begin
          mMem[dataIndex(addr)] = src2;
        end
      end
      default: begin
        // ebreak is the only system instruction in the program
        writes = 1'b0;
        mHalt = 1'b1;
        target = mPc;
      end
    endcase
    if (writes && ins[11:7] != 5'd0) begin
      mRegs[ins[11:7]] = result;
    end
    mPc = target;
  endtask

  task automatic predictOutputs();
    rvPkg::xlenT ins;
    ins = fetchWord(mPc);
    expPc = mPc;
    expHalt = mHalt;
    expWe = !mHalt && ins[6:0] == rvPkg::opStore;
    expAddr = mRegs[ins[19:15]] + {{20{ins[31]}}, ins[31:25], ins[11:7]};
    expWData = mRegs[ins[24:20]];
  endtask

  task automatic printErrorCounts();
    $display("Error counts: reset %0d, pc %0d, store %0d, halt %0d",
             resetErrors, pcErrors, storeErrors, haltErrors);
  endtask

  always @(posedge clk) begin
    if (!rstN) begin
      resetModel();
    end else if (!mHalt) begin
      stepModel();
    end
    predictOutputs();
  end

  // Fetch answers for the pc that settled after the rising edge
  always @(negedge clk) begin
    inst <= fetchWord(pc);
  end

  always @(posedge clk) begin
    if (rstN && dataWe) begin
      if (inDataRange(dataAddr)) begin
        dmem[dataIndex(dataAddr)] <= dataWData;
      end
      storeCount <= storeCount + 1;
    end
  end

  always @(dataAddr or storeCount) begin
    dataRData = inDataRange(dataAddr) ? dmem[dataIndex(dataAddr)] : fillWord(dataAddr);
  end

  always @(posedge clk) begin
    if (!rstN) begin
      cycleCount <= 0;
    end else begin
      cycleCount <= cycleCount + 1;
    end
  end

  resetCheck: assert property (@(posedge clk)
      !rstN |-> (pc == rvPkg::resetPc && !dataWe && !halt))
    else begin
      resetErrors++;
      $display("CHECK FAILED reset pc expected %h actual %h, dataWe %h, halt %h",
               rvPkg::resetPc, $sampled(pc), $sampled(dataWe), $sampled(halt));
    end

  pcCheck: assert property (@(posedge clk) disable iff (!rstN) pc == expPc)
    else begin
      pcErrors++;
      $display("CHECK FAILED pc expected %h actual %h", $sampled(expPc), $sampled(pc));
    end

  weCheck: assert property (@(posedge clk) disable iff (!rstN) dataWe == expWe)
    else begin
      storeErrors++;
      $display("CHECK FAILED dataWe expected %h actual %h", $sampled(expWe),
               $sampled(dataWe));
    end

  addrCheck: assert property (@(posedge clk) disable iff (!rstN)
      expWe |-> dataAddr == expAddr)
    else begin
      storeErrors++;
      $display("CHECK FAILED dataAddr expected %h actual %h", $sampled(expAddr),
               $sampled(dataAddr));
    end

  wdataCheck: assert property (@(posedge clk) disable iff (!rstN)
      expWe |-> dataWData == expWData)
    else begin
      storeErrors++;
      $display("CHECK FAILED dataWData expected %h actual %h", $sampled(expWData),
               $sampled(dataWData));
    end

  haltCheck: assert property (@(posedge clk) disable iff (!rstN) halt == expHalt)
    else begin
      haltErrors++;
      $display("CHECK FAILED halt expected %h actual %h", $sampled(expHalt),
               $sampled(halt));
    end

  haltHoldCheck: assert property (@(posedge clk) disable iff (!rstN) halt |=> halt)
    else begin
      haltErrors++;
      $display("Halt dropped again after it had been raised");
    end

  initial begin
    inst = '0;
    dataRData = '0;
    lcgState = 32'h44c0;
    cycleCount = 0;
    storeCount = 0;
    resetErrors = 0;
    pcErrors = 0;
    storeErrors = 0;
    haltErrors = 0;
    for (int i = 0; i < dmemWords; i++) begin
      dmem[i] = fillWord(dataBase + 32'(4 * i));
      mMem[i] = dmem[i];
    end
    buildProgram();
    // Whole reset pulse first
    @(negedge rstN);
    @(posedge rstN);
    while (!halt && cycleCount < cycleLimit) begin
      @(negedge clk);
    end
    if (!halt) begin
      $display("Timeout after %0d cycles, halt never rose", cycleLimit);
      printErrorCounts();
      $display("Simulation failed");
      $finish;
    end else begin
      // A few frozen cycles after the ebreak
      repeat (haltTail) @(negedge clk);
      printErrorCounts();
      if (resetErrors + pcErrors + storeErrors + haltErrors == 0) begin
        $display("Simulation completed successfully");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

endmodule

/* verilog/rvAlu.sv */
module rvAlu (
  input  rvPkg::xlenT a,
  input  rvPkg::xlenT b,
  input  rvPkg::aluOpE aluOp,
  output rvPkg::xlenT aluOut
);

  rvPkg::xlenT sum;
  rvPkg::xlenT diff;

  // Both wrap at 32 bits
  assign sum = a + b;
  assign diff = a - b;

  always_comb begin
    case (aluOp)
      rvPkg::aluAdd: begin
        aluOut = sum;
      end
      rvPkg::aluSub: begin
        aluOut = diff;
      end
      rvPkg::aluPassB: begin
        // lui result
        aluOut = b;
      end
      default: begin
        aluOut = '0;
      end
    endcase
  end

endmodule

/* verilog/rvCore.sv */
module rvCore (
  input  logic clk,
  input  logic rstN,
  input  rvPkg::xlenT inst,
  output rvPkg::xlenT pc,
  input  rvPkg::xlenT dataRData,
  output rvPkg::xlenT dataAddr,
  output rvPkg::xlenT dataWData,
  output logic dataWe,
  output logic halt
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic funct7b5;
  logic ebreakHint;
  rvPkg::regAddrT rs1;
  rvPkg::regAddrT rs2;
  rvPkg::regAddrT rd;

  rvPkg::ctrlT ctrl;
  rvPkg::xlenT imm;
  rvPkg::xlenT rdata1;
  rvPkg::xlenT rdata2;
  rvPkg::xlenT aluA;
  rvPkg::xlenT aluB;
  rvPkg::xlenT aluOut;
  rvPkg::xlenT pcPlus4;
  rvPkg::xlenT nextPc;
  rvPkg::xlenT wbData;
  logic regWe;
  logic pcEn;

  // Instruction fields
  assign opcode = inst[6:0];
  assign rd = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];
  assign funct7b5 = inst[30];
  // ebreak is 0x00100073, only bit 20 set above the opcode
  assign ebreakHint = (inst[31:7] == 25'h0002000);

  rvDecoder decoder (
    .opcode(opcode),
    .funct3(funct3),
    .funct7b5(funct7b5),
    .ebreakHint(ebreakHint),
    .ctrl(ctrl)
  );

  rvImmGen immGen (
    .instHi(inst[31:7]),
    .immSel(ctrl.immSel),
    .imm(imm)
  );

  rvRegFile regFile (
    .clk(clk),
    .rstN(rstN),
    .wen(regWe),
    .waddr(rd),
    .wdata(wbData),
    .raddr1(rs1),
    .raddr2(rs2),
    .rdata1(rdata1),
    .rdata2(rdata2)
  );

  // Operand muxes
  assign aluA = ctrl.aluASel ? pc : rdata1;
  assign aluB = ctrl.aluBSel ? imm : rdata2;

  rvAlu alu (
    .a(aluA),
    .b(aluB),
    .aluOp(ctrl.aluOp),
    .aluOut(aluOut)
  );

  // Data port
  assign dataAddr = aluOut;
  assign dataWData = rdata2;
  assign dataWe = ctrl.memWrite && !halt;

  // Writeback select
  always_comb begin
    case (ctrl.wbSel)
      rvPkg::wbAlu: wbData = aluOut;
      rvPkg::wbMem: wbData = ctrl.memRead ? dataRData : aluOut;
      rvPkg::wbPcPlus4: wbData = pcPlus4;
      default: wbData = aluOut;
    endcase
  end

  assign regWe = ctrl.regWrite && !halt;

  // Next PC, jump targets lose bit 0 as jalr requires
  assign pcPlus4 = pc + 32'd4;
  assign nextPc = ctrl.pcSel ? {aluOut[31:1], 1'b0} : pcPlus4;

  // PC stays on the ebreak itself
  assign pcEn = !halt && !ctrl.halt;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= rvPkg::resetPc;
    end else if (pcEn) begin
      pc <= nextPc;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      halt <= 1'b0;
    end else if (ctrl.halt) begin
      halt <= 1'b1;
    end
  end

endmodule

/* verilog/rvDecoder.sv */
module rvDecoder (
  input  logic [6:0] opcode,
  input  logic [2:0] funct3,
  input  logic funct7b5,
  input  logic ebreakHint,
  output rvPkg::ctrlT ctrl
);

  always_comb begin
    // Unknown encodings fall through as a no-op
    ctrl = '0;
    case (opcode)
      rvPkg::opLui: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluBSel = 1'b1;
        ctrl.immSel = rvPkg::immU;
        ctrl.aluOp = rvPkg::aluPassB;
        ctrl.wbSel = rvPkg::wbAlu;
      end
      rvPkg::opAuipc: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluASel = 1'b1;
        ctrl.aluBSel = 1'b1;
        ctrl.immSel = rvPkg::immU;
        ctrl.aluOp = rvPkg::aluAdd;
        ctrl.wbSel = rvPkg::wbAlu;
      end
      rvPkg::opJal: begin
        // Target is pc + imm, link is pc + 4
        ctrl.regWrite = 1'b1;
        ctrl.pcSel = 1'b1;
        ctrl.aluASel = 1'b1;
        ctrl.aluBSel = 1'b1;
        ctrl.immSel = rvPkg::immJ;
        ctrl.aluOp = rvPkg::aluAdd;
        ctrl.wbSel = rvPkg::wbPcPlus4;
      end
      rvPkg::opJalr: begin
        if (funct3 == 3'b000) begin
          ctrl.regWrite = 1'b1;
          ctrl.pcSel = 1'b1;
          ctrl.aluBSel = 1'b1;
          ctrl.immSel = rvPkg::immI;
          ctrl.aluOp = rvPkg::aluAdd;
          ctrl.wbSel = rvPkg::wbPcPlus4;
        end
      end
      rvPkg::opOpImm: begin
        // addi only
        if (funct3 == 3'b000) begin
          ctrl.regWrite = 1'b1;
          ctrl.aluBSel = 1'b1;
          ctrl.immSel = rvPkg::immI;
          ctrl.aluOp = rvPkg::aluAdd;
          ctrl.wbSel = rvPkg::wbAlu;
        end
      end
      rvPkg::opOp: begin
        if (funct3 == 3'b000) begin
          ctrl.regWrite = 1'b1;
          ctrl.aluOp = funct7b5 ? rvPkg::aluSub : rvPkg::aluAdd;
          ctrl.wbSel = rvPkg::wbAlu;
        end
      end
      rvPkg::opLoad: begin
        // Word loads only
        if (funct3 == 3'b010) begin
          ctrl.regWrite = 1'b1;
          ctrl.memRead = 1'b1;
          ctrl.aluBSel = 1'b1;
          ctrl.immSel = rvPkg::immI;
          ctrl.aluOp = rvPkg::aluAdd;
          ctrl.wbSel = rvPkg::wbMem;
        end
      end
      rvPkg::opStore: begin
        if (funct3 == 3'b010) begin
          ctrl.memWrite = 1'b1;
          ctrl.aluBSel = 1'b1;
          ctrl.immSel = rvPkg::immS;
          ctrl.aluOp = rvPkg::aluAdd;
        end
      end
      rvPkg::opSystem: begin
        if (funct3 == 3'b000 && ebreakHint) begin
          ctrl.halt = 1'b1;
        end
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

endmodule

/* verilog/rvImmGen.sv */
module rvImmGen (
  input  logic [24:0] instHi,
  input  rvPkg::immSelE immSel,
  output rvPkg::xlenT imm
);

  // instHi[k] holds inst[k+7]
  logic sign;

  assign sign = instHi[24];

  always_comb begin
    case (immSel)
      rvPkg::immI: begin
        imm = {{20{sign}}, instHi[24:13]};
      end
      rvPkg::immS: begin
        // Split field, inst[31:25] and inst[11:7]
        imm = {{20{sign}}, instHi[24:18], instHi[4:0]};
      end
      rvPkg::immU: begin
        imm = {instHi[24:5], 12'b0};
      end
      rvPkg::immJ: begin
        // Scrambled jump offset, always even
        imm = {{12{sign}}, instHi[12:5], instHi[13], instHi[23:14], 1'b0};
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

/* verilog/rvPkg.sv */
package rvPkg;

  // Machine word and register index widths
  localparam int xlen = 32;
  localparam int regAddrW = 5;

  typedef logic [xlen-1:0] xlenT;
  typedef logic [regAddrW-1:0] regAddrT;

  // First fetch address after reset
  localparam xlenT resetPc = 32'h8000_0000;

  // Major opcodes, inst[6:0]
  localparam logic [6:0] opLui = 7'b0110111;
  localparam logic [6:0] opAuipc = 7'b0010111;
  localparam logic [6:0] opJal = 7'b1101111;
  localparam logic [6:0] opJalr = 7'b1100111;
  localparam logic [6:0] opOpImm = 7'b0010011;
  localparam logic [6:0] opOp = 7'b0110011;
  localparam logic [6:0] opLoad = 7'b0000011;
  localparam logic [6:0] opStore = 7'b0100011;
  localparam logic [6:0] opSystem = 7'b1110011;

  // Immediate layouts
  typedef enum logic [1:0] {
    immI = 2'd0,
    immS = 2'd1,
    immU = 2'd2,
    immJ = 2'd3
  } immSelE;

  // ALU functions
  typedef enum logic [1:0] {
    aluAdd = 2'd0,
    aluSub = 2'd1,
    aluPassB = 2'd2
  } aluOpE;

  // Register writeback source
  typedef enum logic [1:0] {
    wbAlu = 2'd0,
    wbMem = 2'd1,
    wbPcPlus4 = 2'd2
  } wbSelE;

  // Decoded control for one instruction
  typedef struct packed {
    logic regWrite;
    logic memWrite;
    logic memRead;
    logic halt;
    // Next PC comes from the ALU
    logic pcSel;
    // Operand A is the PC rather than rs1
    logic aluASel;
    // Operand B is the immediate rather than rs2
    logic aluBSel;
    immSelE immSel;
    aluOpE aluOp;
    wbSelE wbSel;
  } ctrlT;

endpackage

/* verilog/rvRegFile.sv */
module rvRegFile (
  input  logic clk,
  input  logic rstN,
  input  logic wen,
  input  rvPkg::regAddrT waddr,
  input  rvPkg::xlenT wdata,
  input  rvPkg::regAddrT raddr1,
  input  rvPkg::regAddrT raddr2,
  output rvPkg::xlenT rdata1,
  output rvPkg::xlenT rdata2
);

  // x0 has no storage
  rvPkg::xlenT regs [1:31];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // Combinational reads, old value until the edge
  always_comb begin
    if (raddr1 == '0) begin
      rdata1 = '0;
    end else begin
      rdata1 = regs[raddr1];
    end
  end

  always_comb begin
    if (raddr2 == '0) begin
      rdata2 = '0;
    end else begin
      rdata2 = regs[raddr2];
    end
  end

endmodule
